//--- data_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module data_mem (
    input  wire logic                               i_clk,
    input  wire logic                               i_reset,
    input  wire logic                               i_we,
    input  wire logic [$clog2(`DBG_DMEM_WORDS)-1:0] i_wr_addr,
    input  wire logic [31:0]                        i_wr_data,
    input  wire logic [$clog2(`DBG_DMEM_WORDS)-1:0] i_dbg_addr,
    output logic [31:0]                             o_dbg_data
);

    logic [31:0] mem [`DBG_DMEM_WORDS];

    // all words start at zero so the dump only lists what SW wrote
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `DBG_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_dbg_data = mem[i_dbg_addr];    // debug side, no effect on the core

endmodule

`default_nettype wire

//--- dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// machine sizes
`define DBG_NUM_REGS    8
`define DBG_DMEM_WORDS  16
`define DBG_IMEM_WORDS  32
`define DBG_TX_DEPTH    8

// host commands, four ascii characters per word
`define DBG_CMD_LOAD    32'h006c6f6d  // "\0lom"
`define DBG_CMD_CONT    32'h00636f6d  // "\0com"
`define DBG_CMD_STEP    32'h0073746d  // "\0stm"
`define DBG_CMD_NEXT    32'h6e787374  // "nxst"
`define DBG_CMD_CANCEL  32'h636c7374  // "clst"

// last word of a program
`define DBG_END_INSTR   32'hffffffff
// closes every dump, "endd"
`define DBG_END_DATA    32'h656e6464

`endif

//--- dbg_pkg.sv
`default_nettype none
`include "dbg_defs.svh"

package dbg_pkg;

    typedef enum logic [5:0] {
        NOP  = 6'd0,
        ADD  = 6'd1,
        ADDI = 6'd2,
        SW   = 6'd3,
        END  = 6'h3f
    } dbg_opcode_e;

    typedef struct packed {
        dbg_opcode_e opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [10:0] unused;
    } dbg_r_instr_t;

    typedef struct packed {
        dbg_opcode_e opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [15:0] imm;   // sign extended by the core
    } dbg_i_instr_t;

    // one instruction word, read as register or immediate form
    typedef union packed {
        dbg_r_instr_t r;
        dbg_i_instr_t i;
    } dbg_instr_u;

    typedef struct packed {
        logic [31:0] pc;
        dbg_instr_u  instr;
    } dbg_if_id_t;

    typedef struct packed {
        logic                               we;
        logic [$clog2(`DBG_IMEM_WORDS)-1:0] addr;
        dbg_instr_u                         data;
    } dbg_imem_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } dbg_fifo_wr_t;

    typedef struct packed {
        logic        req;
        logic [31:0] word;
    } dbg_rx_t;

endpackage

`default_nettype wire

//--- dbg_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module dbg_top (
    input  wire logic             i_clk,
    input  wire logic             i_reset,
    input  wire dbg_pkg::dbg_rx_t i_rx,
    output wire logic             o_rx_ack,
    output wire logic             o_tx_req,
    output wire logic [31:0]      o_tx_word,
    input  wire logic             i_tx_ack
);

    dbg_pkg::dbg_imem_wr_t                imem_wr;
    dbg_pkg::dbg_instr_u                  instr;
    dbg_pkg::dbg_if_id_t                  if_id;
    dbg_pkg::dbg_fifo_wr_t                push;
    logic [$clog2(`DBG_IMEM_WORDS)-1:0]   imem_addr;
    logic [$clog2(`DBG_NUM_REGS)-1:0]     reg_addr;
    logic [$clog2(`DBG_DMEM_WORDS)-1:0]   dmem_wr_addr;
    logic [$clog2(`DBG_DMEM_WORDS)-1:0]   dmem_dbg_addr;
    logic [31:0]                          reg_data;
    logic [31:0]                          dmem_wdata;
    logic [31:0]                          dmem_dbg_data;
    logic                                 halt;
    logic                                 core_reset;
    logic                                 program_end;
    logic                                 dmem_we;
    logic                                 fifo_full;

    debug_unit u_debug_unit (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rx(i_rx), .o_rx_ack(o_rx_ack),
        .o_imem_wr(imem_wr),
        .o_halt(halt), .o_core_reset(core_reset),
        .i_program_end(program_end), .i_if_id(if_id),
        .o_reg_addr(reg_addr), .i_reg_data(reg_data),
        .o_dmem_addr(dmem_dbg_addr), .i_dmem_data(dmem_dbg_data),
        .o_push(push), .i_fifo_full(fifo_full)
    );

    mini_core u_mini_core (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_core_reset(core_reset), .i_halt(halt),
        .o_imem_addr(imem_addr), .i_instr(instr),
        .o_dmem_we(dmem_we), .o_dmem_addr(dmem_wr_addr), .o_dmem_wdata(dmem_wdata),
        .i_dbg_reg_addr(reg_addr), .o_dbg_reg_data(reg_data),
        .o_if_id(if_id), .o_program_end(program_end)
    );

    instr_mem u_instr_mem (
        .i_clk(i_clk), .i_wr(imem_wr),
        .i_rd_addr(imem_addr), .o_rd_data(instr)
    );

    // data words are cleared together with the core, so every run starts clean
    data_mem u_data_mem (
        .i_clk(i_clk), .i_reset(core_reset),
        .i_we(dmem_we), .i_wr_addr(dmem_wr_addr), .i_wr_data(dmem_wdata),
        .i_dbg_addr(dmem_dbg_addr), .o_dbg_data(dmem_dbg_data)
    );

    tx_fifo u_tx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(push), .o_full(fifo_full),
        .o_tx_req(o_tx_req), .o_tx_word(o_tx_word), .i_tx_ack(i_tx_ack)
    );

endmodule

`default_nettype wire

//--- debug_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module debug_unit (
    input  wire logic                               i_clk,
    input  wire logic                               i_reset,
    input  wire dbg_pkg::dbg_rx_t                   i_rx,
    output logic                                    o_rx_ack,
    output dbg_pkg::dbg_imem_wr_t                   o_imem_wr,
    output logic                                    o_halt,
    output logic                                    o_core_reset,
    input  wire logic                               i_program_end,
    input  wire dbg_pkg::dbg_if_id_t                i_if_id,
    output logic [$clog2(`DBG_NUM_REGS)-1:0]        o_reg_addr,
    input  wire logic [31:0]                        i_reg_data,
    output logic [$clog2(`DBG_DMEM_WORDS)-1:0]      o_dmem_addr,
    input  wire logic [31:0]                        i_dmem_data,
    output dbg_pkg::dbg_fifo_wr_t                   o_push,
    input  wire logic                               i_fifo_full
);

    localparam int DW = $clog2(`DBG_DMEM_WORDS);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD_WAIT,
        S_LOAD_WRITE,
        S_CONT_RUN,
        S_STEP_WAIT,
        S_STEP_RUN,
        S_DUMP_REG,
        S_DUMP_LATCH,
        S_DUMP_MEM_SCAN,
        S_DUMP_MEM_VAL,
        S_DUMP_MEM_ADDR,
        S_DUMP_END
    } state_e;

    state_e state;
    logic   loaded;     // a full program sits in instruction memory
    logic   step_mode;
    logic   latch_sel;  // 0 pc word, 1 instruction word
    logic   accepting;
    logic   take;

    assign accepting = (state == S_IDLE) || (state == S_LOAD_WAIT) || (state == S_STEP_WAIT);
    assign take      = accepting && i_rx.req && !o_rx_ack;

    // core runs only here, and stops in the very cycle END shows up in the latch
    assign o_halt = !((state == S_CONT_RUN && !i_program_end) || state == S_STEP_RUN);

    // dump word for the current state, held back while the FIFO is full
    always_comb begin
        o_push = '0;
        case (state)
            S_DUMP_REG: begin
                o_push.valid = 1'b1;
                o_push.data  = i_reg_data;
            end
            S_DUMP_LATCH: begin
                o_push.valid = 1'b1;
                if (latch_sel) begin
                    o_push.data = i_if_id.instr;
                end else begin
                    o_push.data = i_if_id.pc;
                end
            end
            S_DUMP_MEM_VAL: begin
                o_push.valid = 1'b1;
                o_push.data  = i_dmem_data;
            end
            S_DUMP_MEM_ADDR: begin
                o_push.valid = 1'b1;
                o_push.data  = {{(32-DW){1'b0}}, o_dmem_addr};
            end
            S_DUMP_END: begin
                o_push.valid = 1'b1;
                o_push.data  = `DBG_END_DATA;
            end
            default: ;
        endcase
        if (i_fifo_full) begin
            o_push.valid = 1'b0;
        end
    end

    // four-phase ack, dropped the cycle after req is seen low
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rx_ack <= 1'b0;
        end else if (take) begin
            o_rx_ack <= 1'b1;
        end else if (o_rx_ack && !i_rx.req) begin
            o_rx_ack <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= S_IDLE;
            loaded       <= 1'b0;
            step_mode    <= 1'b0;
            latch_sel    <= 1'b0;
            o_core_reset <= 1'b0;
            o_imem_wr    <= '0;
            o_reg_addr   <= '0;
            o_dmem_addr  <= '0;
        end else begin
            o_core_reset <= 1'b0;   // one cycle pulses only
            case (state)
                S_IDLE: begin
                    if (take) begin
                        if (i_rx.word == `DBG_CMD_LOAD) begin
                            loaded         <= 1'b0;
                            o_imem_wr.addr <= '0;
                            state          <= S_LOAD_WAIT;
                        end else if (i_rx.word == `DBG_CMD_CONT && loaded) begin
                            step_mode <= 1'b0;
                            state     <= S_CONT_RUN;
                        end else if (i_rx.word == `DBG_CMD_STEP && loaded) begin
                            step_mode <= 1'b1;
                            state     <= S_STEP_WAIT;
                        end
                    end
                end
                S_LOAD_WAIT: begin
                    if (take) begin
                        o_imem_wr.we   <= 1'b1;
                        o_imem_wr.data <= i_rx.word;
                        state          <= S_LOAD_WRITE;
                    end
                end
                S_LOAD_WRITE: begin     // memory takes the word at the end of this cycle
                    o_imem_wr.we   <= 1'b0;
                    o_imem_wr.addr <= o_imem_wr.addr + 1'b1;
                    if (o_imem_wr.data == `DBG_END_INSTR) begin
                        loaded       <= 1'b1;
                        o_core_reset <= 1'b1;
                        state        <= S_IDLE;
                    end else begin
                        state <= S_LOAD_WAIT;
                    end
                end
                S_CONT_RUN: if (i_program_end) state <= S_DUMP_REG;
                S_STEP_WAIT: begin
                    if (take && i_rx.word == `DBG_CMD_NEXT) begin
                        state <= S_STEP_RUN;
                    end else if (take && i_rx.word == `DBG_CMD_CANCEL) begin
                        o_core_reset <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                S_STEP_RUN: state <= S_DUMP_REG;    // exactly one unhalted clock
                S_DUMP_REG: begin
                    if (o_push.valid) begin
                        o_reg_addr <= o_reg_addr + 1'b1;    // wraps back to 0
                        if (&o_reg_addr) state <= S_DUMP_LATCH;
                    end
                end
                S_DUMP_LATCH: begin
                    if (o_push.valid) begin
                        latch_sel <= !latch_sel;
                        if (latch_sel) state <= S_DUMP_MEM_SCAN;
                    end
                end
                S_DUMP_MEM_SCAN: begin  // zero words are skipped without a push
                    if (i_dmem_data != '0) begin
                        state <= S_DUMP_MEM_VAL;
                    end else begin
                        o_dmem_addr <= o_dmem_addr + 1'b1;
                        if (&o_dmem_addr) state <= S_DUMP_END;
                    end
                end
                S_DUMP_MEM_VAL: if (o_push.valid) state <= S_DUMP_MEM_ADDR;
                S_DUMP_MEM_ADDR: begin
                    if (o_push.valid) begin
                        o_dmem_addr <= o_dmem_addr + 1'b1;
                        state       <= (&o_dmem_addr) ? S_DUMP_END : S_DUMP_MEM_SCAN;
                    end
                end
                S_DUMP_END: begin
                    if (o_push.valid && step_mode) begin
                        state <= S_STEP_WAIT;
                    end else if (o_push.valid) begin
                        o_core_reset <= 1'b1;   // continue run is over
                        state        <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dbg_pkg.sv
instr_mem.sv
data_mem.sv
mini_core.sv
tx_fifo.sv
debug_unit.sv
dbg_top.sv
tb_dbg_top.sv

//--- instr_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module instr_mem (
    input  wire logic                               i_clk,
    input  wire dbg_pkg::dbg_imem_wr_t              i_wr,
    input  wire logic [$clog2(`DBG_IMEM_WORDS)-1:0] i_rd_addr,
    output dbg_pkg::dbg_instr_u                     o_rd_data
);

    dbg_pkg::dbg_instr_u mem [`DBG_IMEM_WORDS];

    // written only by the debug unit while loading
    always_ff @(posedge i_clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    assign o_rd_data = mem[i_rd_addr];  // async read, fetch in one cycle

endmodule

`default_nettype wire

//--- mini_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module mini_core (
    input  wire logic                               i_clk,
    input  wire logic                               i_reset,
    input  wire logic                               i_core_reset,
    input  wire logic                               i_halt,
    output logic [$clog2(`DBG_IMEM_WORDS)-1:0]      o_imem_addr,
    input  wire dbg_pkg::dbg_instr_u                i_instr,
    output logic                                    o_dmem_we,
    output logic [$clog2(`DBG_DMEM_WORDS)-1:0]      o_dmem_addr,
    output logic [31:0]                             o_dmem_wdata,
    input  wire logic [$clog2(`DBG_NUM_REGS)-1:0]   i_dbg_reg_addr,
    output logic [31:0]                             o_dbg_reg_data,
    output dbg_pkg::dbg_if_id_t                     o_if_id,
    output logic                                    o_program_end
);

    localparam int RW = $clog2(`DBG_NUM_REGS);
    localparam int DW = $clog2(`DBG_DMEM_WORDS);
    localparam int IW = $clog2(`DBG_IMEM_WORDS);

    logic [31:0]   pc;                      // word addressed
    logic [31:0]   regs [`DBG_NUM_REGS];
    logic [RW-1:0] rd;
    logic [RW-1:0] rs;
    logic [RW-1:0] rt;
    logic [31:0]   rs_val;
    logic [31:0]   rt_val;
    logic [31:0]   imm_ext;
    logic [31:0]   rs_imm;
    logic          reg_we;
    logic [31:0]   reg_wdata;

    // only the low bits of the register fields select one of the 8 registers
    assign rd = o_if_id.instr.r.rd[RW-1:0];
    assign rs = o_if_id.instr.r.rs[RW-1:0];
    assign rt = o_if_id.instr.r.rt[RW-1:0];

    assign rs_val  = regs[rs];
    assign rt_val  = regs[rt];
    assign imm_ext = {{16{o_if_id.instr.i.imm[15]}}, o_if_id.instr.i.imm};
    assign rs_imm  = rs_val + imm_ext;    // ADDI result and SW address

    assign o_imem_addr    = pc[IW-1:0];
    assign o_dmem_addr    = rs_imm[DW-1:0];  // wraps over the 16 data words
    assign o_dmem_wdata   = regs[rd];
    assign o_dbg_reg_data = regs[i_dbg_reg_addr];
    assign o_program_end  = (o_if_id.instr.r.opcode == dbg_pkg::END);

    // execute stage, works on the latch in the same cycle it is filled
    always_comb begin
        reg_we    = 1'b0;
        reg_wdata = rs_val + rt_val;
        o_dmem_we = 1'b0;
        case (o_if_id.instr.r.opcode)
            dbg_pkg::ADD: begin
                reg_we = !i_halt;
            end
            dbg_pkg::ADDI: begin
                reg_we    = !i_halt;
                reg_wdata = rs_imm;
            end
            dbg_pkg::SW: begin
                o_dmem_we = !i_halt;
            end
            default: ;  // NOP and END
        endcase
    end

    // fetch, pc back to 0 and latch to NOP on either reset
    always_ff @(posedge i_clk) begin
        if (i_reset || i_core_reset) begin
            pc      <= '0;
            o_if_id <= '0;
        end else if (!i_halt) begin
            pc            <= pc + 32'd1;
            o_if_id.pc    <= pc;
            o_if_id.instr <= i_instr;
        end
    end

    // register file is cleared with the core so each run starts from zero
    always_ff @(posedge i_clk) begin
        if (i_reset || i_core_reset) begin
            for (int i = 0; i < `DBG_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && rd != '0) begin   // r0 stays zero
            regs[rd] <= reg_wdata;
        end
    end

endmodule

`default_nettype wire

//--- tb_dbg_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module tb_dbg_top;

    localparam logic [5:0] OP_ADD  = 6'd1;
    localparam logic [5:0] OP_ADDI = 6'd2;
    localparam logic [5:0] OP_SW   = 6'd3;
    // about ten dumps of under 20 words at up to 16 cycles a word, plus loading
    localparam int TIMEOUT_CYCLES = 4000;

    logic             clk = 1'b0;
    logic             reset;
    dbg_pkg::dbg_rx_t rx;
    logic             tx_ack;
    wire logic        rx_ack;
    wire logic        tx_req;
    wire logic [31:0] tx_word;

    logic [31:0] prog [$];      // program as sent to the host link
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    int unsigned lcg_state = 96899;
    int          cycle_count = 0;
    int          k;

    dbg_top i_dut (
        .i_clk(clk), .i_reset(reset),
        .i_rx(rx), .o_rx_ack(rx_ack),
        .o_tx_req(tx_req), .o_tx_word(tx_word), .i_tx_ack(tx_ack)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run hung after %0d cycles", cycle_count);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {op, rd, rs, rt, 11'd0};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic int end_index();
        foreach (prog[i]) begin
            if (prog[i] == `DBG_END_INSTR) return i;
        end
        return prog.size() - 1;
    endfunction

    task automatic report_value_error(input string what, input int idx,
                                      input logic [31:0] expected, input logic [31:0] got);
        $display("** Error at %0t: %s word %0d expected %h got %h",
                 $time, what, idx, expected, got);
        $display("Some tests failed");
        $fatal(1, "wrong dump word");
    endtask

    task automatic report_failure(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "check failed");
    endtask

    // full four-phase handshake on the command link
    task automatic send_word(input logic [31:0] word);
        @(negedge clk);
        rx.word = word;
        rx.req  = 1'b1;
        @(negedge clk);
        while (!rx_ack) @(negedge clk);
        rx.req = 1'b0;
        @(negedge clk);
        while (rx_ack) @(negedge clk);
    endtask

    task automatic load_program();
        send_word(`DBG_CMD_LOAD);
        foreach (prog[i]) begin
            send_word(prog[i]);
        end
    endtask

    // drains one dump, up to the end marker
    task automatic receive_dump(input bit slow);
        logic [31:0] word;
        int          delay;
        bit          done;
        got_q.delete();
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (tx_req) begin
                if (slow) begin
                    lcg_state = lcg_next(lcg_state);
                    delay     = (lcg_state >> 16) % 13;
                    repeat (delay) @(negedge clk);    // lets the FIFO fill up
                end
                word = tx_word;
                got_q.push_back(word);
                tx_ack = 1'b1;
                while (tx_req) @(negedge clk);
                tx_ack = 1'b0;
                done   = (word == `DBG_END_DATA);
            end
        end
    endtask

    // ISA model: instructions 0 .. n_exec-1 done, latch holds instruction n_exec
    task automatic build_expected(input int n_exec);
        logic [31:0] regs [`DBG_NUM_REGS];
        logic [31:0] mem [`DBG_DMEM_WORDS];
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] addr;
        int          rd;
        int          rs;
        int          rt;
        exp_q.delete();
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        for (int i = 0; i < n_exec; i++) begin
            w   = prog[i];
            rd  = w[23:21];     // 8 registers, low bits of each field
            rs  = w[18:16];
            rt  = w[13:11];
            imm = {{16{w[15]}}, w[15:0]};
            case (w[31:26])
                OP_ADD:  if (rd != 0) regs[rd] = regs[rs] + regs[rt];
                OP_ADDI: if (rd != 0) regs[rd] = regs[rs] + imm;
                OP_SW: begin
                    addr = (regs[rs] + imm) % `DBG_DMEM_WORDS;
                    mem[addr] = regs[rd];
                end
                default: ;
            endcase
        end
        foreach (regs[i]) exp_q.push_back(regs[i]);
        exp_q.push_back(n_exec);
        exp_q.push_back(prog[n_exec]);
        foreach (mem[i]) begin
            if (mem[i] != '0) begin
                exp_q.push_back(mem[i]);
                exp_q.push_back(i);
            end
        end
        exp_q.push_back(`DBG_END_DATA);
    endtask

    task automatic check_dump(input string what);
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            assert (got_q[i] === exp_q[i])
                else report_value_error(what, i, exp_q[i], got_q[i]);
        end
        assert (got_q.size() == exp_q.size())
            else report_failure($sformatf("%s dump has %0d words instead of %0d",
                                          what, got_q.size(), exp_q.size()));
    endtask

    initial begin
        reset  = 1'b1;
        rx     = '0;
        tx_ack = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // nothing loaded yet, continue must be ignored
        send_word(`DBG_CMD_CONT);
        repeat (50) begin
            @(negedge clk);
            assert (!tx_req) else report_failure("transmit request with no program loaded");
        end

        prog = '{enc_i(OP_ADDI, 1, 0, 16'd5),
                 enc_i(OP_ADDI, 2, 0, 16'hfffd),
                 enc_r(OP_ADD, 3, 1, 2),
                 enc_i(OP_SW, 1, 0, 16'd4),
                 enc_i(OP_SW, 3, 1, 16'd12),    // address wraps to 1
                 enc_i(OP_ADDI, 7, 3, 16'h0100),
                 enc_r(OP_ADD, 0, 1, 1),        // r0 keeps zero
                 `DBG_END_INSTR};
        load_program();
        build_expected(end_index());
        send_word(`DBG_CMD_CONT);
        receive_dump(1'b0);
        check_dump("continue");

        send_word(`DBG_CMD_CONT);
        receive_dump(1'b1);
        check_dump("slow continue");

        send_word(`DBG_CMD_STEP);
        for (k = 1; k <= 6; k++) begin
            send_word(`DBG_CMD_NEXT);
            receive_dump(k[0]);
            build_expected(k - 1);
            check_dump($sformatf("step %0d", k));
        end

        send_word(`DBG_CMD_CANCEL);
        build_expected(end_index());
        send_word(`DBG_CMD_CONT);
        receive_dump(1'b1);
        check_dump("continue after cancel");

        prog = '{enc_i(OP_ADDI, 4, 0, 16'h07ff),
                 enc_i(OP_ADDI, 5, 4, 16'hf800),
                 enc_i(OP_SW, 5, 0, 16'd15),
                 enc_r(OP_ADD, 6, 5, 4),
                 enc_i(OP_SW, 6, 5, 16'd1),     // -1 + 1 lands on word 0
                 `DBG_END_INSTR};
        load_program();
        build_expected(end_index());
        send_word(`DBG_CMD_CONT);
        receive_dump(1'b0);
        check_dump("second program");

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_defs.svh"

module tx_fifo (
    input  wire logic                  i_clk,
    input  wire logic                  i_reset,
    input  wire dbg_pkg::dbg_fifo_wr_t i_push,
    output logic                       o_full,
    output logic                       o_tx_req,
    output logic [31:0]                o_tx_word,
    input  wire logic                  i_tx_ack
);

    localparam int           AW    = $clog2(`DBG_TX_DEPTH);
    localparam logic [AW:0]  DEPTH = `DBG_TX_DEPTH;

    typedef enum logic {
        TX_IDLE,
        TX_REQ
    } tx_state_e;

    tx_state_e     tx_state;
    logic [31:0]   entries [`DBG_TX_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign o_full    = (count == DEPTH);
    assign push      = i_push.valid && !o_full;
    assign o_tx_req  = (tx_state == TX_REQ);
    assign pop       = o_tx_req && i_tx_ack;  // one pop per handshake
    assign o_tx_word = entries[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            entries[wr_ptr] <= i_push.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            tx_state <= TX_IDLE;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case (tx_state)
                TX_IDLE: if (!i_tx_ack && count != '0) tx_state <= TX_REQ; // ack seen low
                TX_REQ:  if (i_tx_ack) tx_state <= TX_IDLE;
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
